//--- compile.f
design/mio_route_pkg.sv
design/emesh_priority_mux.sv
design/slave_req_decode.sv
design/mio_reg_block.sv
design/rx_dispatch.sv
design/response_arbiter.sv
design/mio_route_top.sv
tb/mio_route_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= mio_route_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ALL TESTS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: run build lint clean

run: build
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

build: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb/mio_route_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mio_route_tb;

   localparam int clk_period   = 10;       // ns
   localparam int reset_cycles = 5;
   localparam int n_cycles     = 4000;     // Random traffic cycles

   logic                      sys_clk;
   logic                      rst_n;
   mio_route_pkg::emesh_req_t s_wr, s_rd, m_rr, mio_rx;      // Driven requests
   mio_route_pkg::emesh_req_t mio_tx, s_rr, m_wr, m_rd;      // Routed outputs
   logic                      s_rr_wait, m_wr_wait, m_rd_wait, mio_tx_wait;
   logic                      s_wr_wait, s_rd_wait, m_rr_wait, mio_rx_wait;

   logic [31:0]                  rng_state;                   // xorshift state
   logic [31:0]                  model_regs [mio_route_pkg::reg_words];
   logic                         pend_valid;                  // Expected reg response
   mio_route_pkg::emesh_packet_t pend_pkt;
   logic                         hold_swr, hold_srd, hold_mrr, hold_rx; // Stalled sources
   int                           checks;
   int                           errors;
   int                           reg_reads;                   // Accepted register reads

   mio_route_top DUT (
      .sys_clk     (sys_clk),
      .rst_n       (rst_n),
      .s_wr        (s_wr),
      .s_wr_wait   (s_wr_wait),
      .s_rd        (s_rd),
      .s_rd_wait   (s_rd_wait),
      .s_rr        (s_rr),
      .s_rr_wait   (s_rr_wait),
      .m_wr        (m_wr),
      .m_wr_wait   (m_wr_wait),
      .m_rd        (m_rd),
      .m_rd_wait   (m_rd_wait),
      .m_rr        (m_rr),
      .m_rr_wait   (m_rr_wait),
      .mio_tx      (mio_tx),
      .mio_tx_wait (mio_tx_wait),
      .mio_rx      (mio_rx),
      .mio_rx_wait (mio_rx_wait)
   );

   initial begin
      sys_clk = 1'b0;
      forever #(clk_period / 2) sys_clk = ~sys_clk;
   end

   // Hard stop if the traffic loop stalls
   initial begin
      #((reset_cycles + n_cycles + 2) * clk_period + 500);
      $display("Watchdog expired before the traffic loop completed");
      $display("SOME TESTS FAILED");
      $finish;
   end

   //##########################################################
   // Random sources
   //##########################################################

   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic mio_route_pkg::emesh_req_t rand_req();
      mio_route_pkg::emesh_req_t r;
      logic [31:0]               v;
      logic [31:0]               w;
      v = next_rand();
      w = next_rand();
      r.access          = v[0] | v[1];                       // Busy three cycles in four
      r.packet.write    = v[2];
      r.packet.datamode = v[4:3];
      r.packet.ctrlmode = v[9:5];
      case (v[11:10])
         2'd2:    r.packet.dstaddr[31:20] = mio_route_pkg::remap_id;
         2'd3:    r.packet.dstaddr[31:20] = w[31:20];
         default: r.packet.dstaddr[31:20] = mio_route_pkg::id; // Local half the time
      endcase
      r.packet.dstaddr[19:16] = v[12] ? mio_route_pkg::egroup_rr : v[16:13];
      r.packet.dstaddr[15:0]  = w[15:0];                     // Register index in [5:2]
      r.packet.data           = next_rand();
      r.packet.srcaddr        = next_rand();
      return r;
   endfunction

   function automatic logic rand_wait();
      logic [31:0] v;
      v = next_rand();
      return (v[1:0] == 2'd0);                               // About one in four
   endfunction

   //##########################################################
   // Compare tasks
   //##########################################################

   task automatic check_req(input string name, input mio_route_pkg::emesh_req_t got,
                            input mio_route_pkg::emesh_req_t exp);
      checks++;
      if ((got.access !== exp.access) ||
          ((exp.access === 1'b1) && (got.packet !== exp.packet))) begin
         errors++;
         $display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_wait(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_idle();
      check_req("mio_tx", mio_tx, '0);                       // Access only
      check_req("s_rr", s_rr, '0);
      check_req("m_wr", m_wr, '0);
      check_req("m_rd", m_rd, '0);
      check_wait("s_wr_wait", s_wr_wait, 1'b0);
      check_wait("s_rd_wait", s_rd_wait, 1'b0);
      check_wait("m_rr_wait", m_rr_wait, 1'b0);
      check_wait("mio_rx_wait", mio_rx_wait, 1'b0);
   endtask

   //##########################################################
   // Reference model for one cycle
   //##########################################################

   task automatic check_cycle();
      mio_route_pkg::emesh_req_t wr_far, rd_far, tx_exp, rr_exp, mwr_exp, mrd_exp;
      mio_route_pkg::rx_route_e  route;
      logic                      wr_loc, rd_loc, rx_rr, reg_busy, rx_w;
      logic [2:0]                tx_w;
      logic [1:0]                reg_w;
      wr_loc = s_wr.access && (s_wr.packet.dstaddr[31:20] == mio_route_pkg::id);
      rd_loc = s_rd.access && (s_rd.packet.dstaddr[31:20] == mio_route_pkg::id);
      wr_far = s_wr;
      wr_far.access = s_wr.access && !wr_loc;
      wr_far.packet.dstaddr[31:20] = mio_route_pkg::remap_id; // Far side id
      rd_far = s_rd;
      rd_far.access = s_rd.access && !rd_loc;
      rd_far.packet.dstaddr[31:20] = mio_route_pkg::remap_id;
      // Receive classification
      if ((mio_rx.packet.dstaddr[31:20] == mio_route_pkg::id) &&
          (mio_rx.packet.dstaddr[19:16] == mio_route_pkg::egroup_rr)) begin
         route = mio_route_pkg::route_rr;
      end else if (mio_rx.packet.write) begin
         route = mio_route_pkg::route_mwr;
      end else begin
         route = mio_route_pkg::route_mrd;
      end
      rx_rr   = mio_rx.access && (route == mio_route_pkg::route_rr);
      mwr_exp = mio_rx;
      mwr_exp.access = mio_rx.access && (route == mio_route_pkg::route_mwr);
      mrd_exp = mio_rx;
      mrd_exp.access = mio_rx.access && (route == mio_route_pkg::route_mrd);
      rx_w = (route == mio_route_pkg::route_rr)  ? s_rr_wait :
             (route == mio_route_pkg::route_mwr) ? m_wr_wait : m_rd_wait;
      // Response port with MIO first
      reg_busy = pend_valid && (rx_rr || s_rr_wait);
      rr_exp.access = pend_valid;
      rr_exp.packet = pend_pkt;
      if (rx_rr) begin
         rr_exp = mio_rx;
      end
      // Transmit priority s_wr, s_rd, m_rr
      tx_exp = '0;
      tx_w   = '0;
      if (wr_far.access) begin
         tx_exp  = wr_far;
         tx_w[0] = mio_tx_wait;
      end
      if (rd_far.access) begin
         if (tx_exp.access) begin
            tx_w[1] = 1'b1;                                  // Behind the write
         end else begin
            tx_exp  = rd_far;
            tx_w[1] = mio_tx_wait;
         end
      end
      if (m_rr.access) begin
         if (tx_exp.access) begin
            tx_w[2] = 1'b1;
         end else begin
            tx_exp  = m_rr;
            tx_w[2] = mio_tx_wait;
         end
      end
      reg_w[0] = wr_loc && reg_busy;
      reg_w[1] = rd_loc && (wr_loc || reg_busy);            // Write goes first
      check_req("mio_tx", mio_tx, tx_exp);
      check_req("s_rr", s_rr, rr_exp);
      check_req("m_wr", m_wr, mwr_exp);
      check_req("m_rd", m_rd, mrd_exp);
      check_wait("s_wr_wait", s_wr_wait, wr_loc ? reg_w[0] : tx_w[0]);
      check_wait("s_rd_wait", s_rd_wait, rd_loc ? reg_w[1] : tx_w[1]);
      check_wait("m_rr_wait", m_rr_wait, tx_w[2]);
      if (mio_rx.access) begin
         check_wait("mio_rx_wait", mio_rx_wait, rx_w);
      end
      // State after the coming edge
      if (pend_valid && !reg_busy) begin
         pend_valid = 1'b0;                                  // Granted
      end
      if (rd_loc && !reg_w[1]) begin
         pend_valid        = 1'b1;
         pend_pkt.write    = 1'b1;
         pend_pkt.datamode = s_rd.packet.datamode;
         pend_pkt.ctrlmode = s_rd.packet.ctrlmode;
         pend_pkt.dstaddr  = s_rd.packet.srcaddr;
         pend_pkt.data     = model_regs[s_rd.packet.dstaddr[5:2]];
         pend_pkt.srcaddr  = s_rd.packet.dstaddr;
         reg_reads++;
      end
      if (wr_loc && !reg_w[0]) begin
         model_regs[s_wr.packet.dstaddr[5:2]] = s_wr.packet.data;
      end
      hold_swr = s_wr.access && (wr_loc ? reg_w[0] : tx_w[0]);
      hold_srd = s_rd.access && (rd_loc ? reg_w[1] : tx_w[1]);
      hold_mrr = m_rr.access && tx_w[2];
      hold_rx  = mio_rx.access && rx_w;
   endtask

   //##########################################################
   // Main sequence
   //##########################################################

   initial begin
      mio_route_pkg::emesh_req_t nxt;
      rng_state  = 32'hde53_c0c6;
      checks     = 0;
      errors     = 0;
      reg_reads  = 0;
      pend_valid = 1'b0;
      pend_pkt   = '0;
      hold_swr   = 1'b0;
      hold_srd   = 1'b0;
      hold_mrr   = 1'b0;
      hold_rx    = 1'b0;
      for (int i = 0; i < mio_route_pkg::reg_words; i++) begin
         model_regs[i] = '0;
      end
      rst_n       = 1'b0;
      s_wr        = '0;
      s_rd        = '0;
      m_rr        = '0;
      mio_rx      = '0;
      s_rr_wait   = 1'b0;
      m_wr_wait   = 1'b0;
      m_rd_wait   = 1'b0;
      mio_tx_wait = 1'b0;
      repeat (reset_cycles) @(posedge sys_clk);
      rst_n <= 1'b1;
      @(negedge sys_clk);
      check_idle();
      repeat (n_cycles) begin
         @(posedge sys_clk);
         if (!hold_swr) begin
            nxt = rand_req();
            nxt.packet.write = 1'b1;                         // Slave write channel
            s_wr <= nxt;
         end
         if (!hold_srd) begin
            nxt = rand_req();
            nxt.packet.write = 1'b0;                         // Slave read channel
            s_rd <= nxt;
         end
         if (!hold_mrr) begin
            m_rr <= rand_req();
         end
         if (!hold_rx) begin
            mio_rx <= rand_req();
         end
         s_rr_wait   <= rand_wait();
         m_wr_wait   <= rand_wait();
         m_rd_wait   <= rand_wait();
         mio_tx_wait <= rand_wait();
         @(negedge sys_clk);
         check_cycle();
      end
      $display("Checks: %0d  Errors: %0d  Register reads: %0d", checks, errors, reg_reads);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- design/mio_route_top.sv
`timescale 1ns/1ps
`default_nettype none

module mio_route_top (
   input  logic                      sys_clk,
   input  logic                      rst_n,
   // Slave side
   input  mio_route_pkg::emesh_req_t s_wr,
   output logic                      s_wr_wait,
   input  mio_route_pkg::emesh_req_t s_rd,
   output logic                      s_rd_wait,
   output mio_route_pkg::emesh_req_t s_rr,
   input  logic                      s_rr_wait,
   // Master side
   output mio_route_pkg::emesh_req_t m_wr,
   input  logic                      m_wr_wait,
   output mio_route_pkg::emesh_req_t m_rd,
   input  logic                      m_rd_wait,
   input  mio_route_pkg::emesh_req_t m_rr,
   output logic                      m_rr_wait,
   // MIO link
   output mio_route_pkg::emesh_req_t mio_tx,
   input  logic                      mio_tx_wait,
   input  mio_route_pkg::emesh_req_t mio_rx,
   output logic                      mio_rx_wait
);

   mio_route_pkg::emesh_req_t wr_mio, rd_mio;   // Remapped slave requests
   mio_route_pkg::emesh_req_t wr_reg, rd_reg;   // Local slave requests
   mio_route_pkg::emesh_req_t tx_in [3];        // s_wr, s_rd, m_rr
   mio_route_pkg::emesh_req_t reg_in [2];       // s_wr, s_rd
   mio_route_pkg::emesh_req_t reg_req;          // Into register block
   mio_route_pkg::emesh_req_t reg_resp;         // Register read response
   mio_route_pkg::emesh_req_t rr_cand;          // MIO read response
   logic [2:0]                tx_wait;
   logic [1:0]                reg_in_wait;
   logic                      reg_req_wait;
   logic                      reg_resp_wait;
   logic                      rr_cand_wait;

   //##########################################################
   // Slave request split
   //##########################################################

   slave_req_decode u_decode (
      .s_wr        (s_wr),
      .s_rd        (s_rd),
      .wr_mio      (wr_mio),
      .rd_mio      (rd_mio),
      .wr_reg      (wr_reg),
      .rd_reg      (rd_reg),
      .wr_mio_wait (tx_wait[0]),
      .rd_mio_wait (tx_wait[1]),
      .wr_reg_wait (reg_in_wait[0]),
      .rd_reg_wait (reg_in_wait[1]),
      .s_wr_wait   (s_wr_wait),
      .s_rd_wait   (s_rd_wait)
   );

   //##########################################################
   // MIO transmit and register muxes
   //##########################################################

   assign tx_in[0]  = wr_mio;                   // Highest priority
   assign tx_in[1]  = rd_mio;
   assign tx_in[2]  = m_rr;                     // Master read responses last
   assign m_rr_wait = tx_wait[2];

   emesh_priority_mux #(.n(3)) tx_mux (
      .req_in   (tx_in),
      .wait_in  (mio_tx_wait),
      .req_out  (mio_tx),
      .wait_out (tx_wait)
   );

   assign reg_in[0] = wr_reg;
   assign reg_in[1] = rd_reg;

   emesh_priority_mux #(.n(2)) reg_mux (
      .req_in   (reg_in),
      .wait_in  (reg_req_wait),
      .req_out  (reg_req),
      .wait_out (reg_in_wait)
   );

   mio_reg_block u_regs (
      .sys_clk   (sys_clk),
      .rst_n     (rst_n),
      .req       (reg_req),
      .req_wait  (reg_req_wait),
      .resp      (reg_resp),
      .resp_wait (reg_resp_wait)
   );

   //##########################################################
   // MIO receive and slave read response
   //##########################################################

   rx_dispatch u_rx (
      .rx        (mio_rx),
      .rx_wait   (mio_rx_wait),
      .rr_cand   (rr_cand),
      .m_wr      (m_wr),
      .m_rd      (m_rd),
      .rr_wait   (rr_cand_wait),
      .m_wr_wait (m_wr_wait),
      .m_rd_wait (m_rd_wait)
   );

   response_arbiter u_rr_arb (
      .mio_rr      (rr_cand),
      .reg_rr      (reg_resp),
      .s_rr_wait   (s_rr_wait),
      .s_rr        (s_rr),
      .mio_rr_wait (rr_cand_wait),
      .reg_rr_wait (reg_resp_wait)
   );

endmodule

`default_nettype wire

//--- design/response_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module response_arbiter (
   input  mio_route_pkg::emesh_req_t mio_rr,      // From MIO receive
   input  mio_route_pkg::emesh_req_t reg_rr,      // From register block
   input  logic                      s_rr_wait,   // Slave port stall
   output mio_route_pkg::emesh_req_t s_rr,        // Slave read response
   output logic                      mio_rr_wait,
   output logic                      reg_rr_wait
);

   //##########################################################
   // Fixed priority with MIO first
   //##########################################################

   assign s_rr = mio_rr.access ? mio_rr : reg_rr;

   assign mio_rr_wait = mio_rr.access & s_rr_wait;                  // Winner
   assign reg_rr_wait = reg_rr.access & (mio_rr.access | s_rr_wait); // Loses to MIO

   // Two responses can never both move onto the one port
   always_comb begin
      assert final (!((mio_rr.access === 1'b1) && (reg_rr.access === 1'b1)) ||
                    mio_rr_wait || reg_rr_wait)
         else $error("response_arbiter: both responses granted");
   end

endmodule

`default_nettype wire

//--- design/rx_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module rx_dispatch (
   input  mio_route_pkg::emesh_req_t rx,        // MIO receive packet
   output logic                      rx_wait,   // Back-pressure to MIO rx
   output mio_route_pkg::emesh_req_t rr_cand,   // To response arbiter
   output mio_route_pkg::emesh_req_t m_wr,      // Master write port
   output mio_route_pkg::emesh_req_t m_rd,      // Master read port
   input  logic                      rr_wait,
   input  logic                      m_wr_wait,
   input  logic                      m_rd_wait
);

   mio_route_pkg::rx_route_e route;             // Chosen destination
   logic                     rr_hit;            // Local read-response address

   //##########################################################
   // Classify
   //##########################################################

   assign rr_hit = (rx.packet.dstaddr[31:20] == mio_route_pkg::id) &&
                   (rx.packet.dstaddr[19:16] == mio_route_pkg::egroup_rr);

   always_comb begin
      if (rr_hit) begin
         route = mio_route_pkg::route_rr;       // Answer to a slave read
      end else if (rx.packet.write) begin
         route = mio_route_pkg::route_mwr;
      end else begin
         route = mio_route_pkg::route_mrd;
      end
   end

   //##########################################################
   // Steer access and wait
   //##########################################################

   always_comb begin
      rr_cand        = rx;                      // Packet fanned out to all
      m_wr           = rx;
      m_rd           = rx;
      rr_cand.access = rx.access && (route == mio_route_pkg::route_rr);
      m_wr.access    = rx.access && (route == mio_route_pkg::route_mwr);
      m_rd.access    = rx.access && (route == mio_route_pkg::route_mrd);
      unique case (route)
         mio_route_pkg::route_rr:  rx_wait = rr_wait;
         mio_route_pkg::route_mwr: rx_wait = m_wr_wait;
         default:                  rx_wait = m_rd_wait;
      endcase
   end

endmodule

`default_nettype wire

//--- design/mio_reg_block.sv
`timescale 1ns/1ps
`default_nettype none

module mio_reg_block (
   input  logic                      sys_clk,
   input  logic                      rst_n,
   input  mio_route_pkg::emesh_req_t req,       // Write or read request
   output logic                      req_wait,  // Stall while resp blocked
   output mio_route_pkg::emesh_req_t resp,      // Read response
   input  logic                      resp_wait  // Response not granted
);

   logic [mio_route_pkg::aw-1:0]        regs [mio_route_pkg::reg_words];
   logic [mio_route_pkg::reg_idx_w-1:0] idx;        // Word select
   logic                                req_fire;   // Request accepted
   logic                                wr_fire;    // Accepted write
   logic                                rd_fire;    // Accepted read
   logic                                resp_valid; // Response pending
   mio_route_pkg::emesh_packet_t        resp_pkt;   // Response payload

   assign idx      = req.packet.dstaddr[5:2];
   assign req_wait = resp_valid & resp_wait;   // Held response blocks new work
   assign req_fire = req.access & ~req_wait;
   assign wr_fire  = req_fire & req.packet.write;
   assign rd_fire  = req_fire & ~req.packet.write;

   //##########################################################
   // Register file
   //##########################################################

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < mio_route_pkg::reg_words; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_fire) begin
         regs[idx] <= req.packet.data;         // Write lands this edge
      end
   end

   //##########################################################
   // Read response
   //##########################################################

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         resp_valid <= 1'b0;
      end else if (rd_fire) begin
         resp_valid <= 1'b1;                   // Valid from next cycle
      end else if (!resp_wait) begin
         resp_valid <= 1'b0;                   // Taken by arbiter
      end
   end

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         resp_pkt <= '0;
      end else if (rd_fire) begin
         resp_pkt.write    <= 1'b1;            // Response goes back as write
         resp_pkt.datamode <= req.packet.datamode;
         resp_pkt.ctrlmode <= req.packet.ctrlmode;
         resp_pkt.dstaddr  <= req.packet.srcaddr; // Back to requester
         resp_pkt.data     <= regs[idx];
         resp_pkt.srcaddr  <= req.packet.dstaddr;
      end
   end

   assign resp = '{access: resp_valid, packet: resp_pkt};

   // A stalled response must stay put until the arbiter takes it
   a_resp_hold: assert property (
      @(posedge sys_clk) disable iff (!rst_n)
      (resp.access && resp_wait) |=> (resp.access && $stable(resp.packet))
   ) else $error("mio_reg_block: held response changed");

endmodule

`default_nettype wire

//--- design/slave_req_decode.sv
`timescale 1ns/1ps
`default_nettype none

module slave_req_decode (
   input  mio_route_pkg::emesh_req_t s_wr,        // Slave write request
   input  mio_route_pkg::emesh_req_t s_rd,        // Slave read request
   output mio_route_pkg::emesh_req_t wr_mio,      // Write toward MIO tx
   output mio_route_pkg::emesh_req_t rd_mio,      // Read toward MIO tx
   output mio_route_pkg::emesh_req_t wr_reg,      // Write toward registers
   output mio_route_pkg::emesh_req_t rd_reg,      // Read toward registers
   input  logic                      wr_mio_wait,
   input  logic                      rd_mio_wait,
   input  logic                      wr_reg_wait,
   input  logic                      rd_reg_wait,
   output logic                      s_wr_wait,
   output logic                      s_rd_wait
);

   logic wr_match;                        // Write hits local id
   logic rd_match;                        // Read hits local id

   // Swap the id field for the far side of the link
   function automatic mio_route_pkg::emesh_req_t remap(
      input mio_route_pkg::emesh_req_t r
   );
      mio_route_pkg::emesh_req_t o;
      o                      = r;
      o.packet.dstaddr[31:20] = mio_route_pkg::remap_id;
      return o;
   endfunction

   //##########################################################
   // Address match and split
   //##########################################################

   assign wr_match = (s_wr.packet.dstaddr[31:20] == mio_route_pkg::id);
   assign rd_match = (s_rd.packet.dstaddr[31:20] == mio_route_pkg::id);

   always_comb begin
      wr_reg        = s_wr;                      // Local side unchanged
      wr_reg.access = s_wr.access & wr_match;
      wr_mio        = remap(s_wr);
      wr_mio.access = s_wr.access & ~wr_match;   // Everything else to MIO
      rd_reg        = s_rd;
      rd_reg.access = s_rd.access & rd_match;
      rd_mio        = remap(s_rd);
      rd_mio.access = s_rd.access & ~rd_match;
   end

   // Stall only on the path actually taken
   assign s_wr_wait = (wr_reg.access & wr_reg_wait) | (wr_mio.access & wr_mio_wait);
   assign s_rd_wait = (rd_reg.access & rd_reg_wait) | (rd_mio.access & rd_mio_wait);

endmodule

`default_nettype wire

//--- design/emesh_priority_mux.sv
`timescale 1ns/1ps
`default_nettype none

module emesh_priority_mux #(
   parameter int n = 3                    // Input count with index 0 highest
) (
   input  mio_route_pkg::emesh_req_t req_in [n], // Candidates
   input  logic                      wait_in,    // Wait from the shared sink
   output mio_route_pkg::emesh_req_t req_out,    // Selected packet
   output logic [n-1:0]              wait_out    // Per-input stall
);

   logic         found;                   // A winner already taken
   logic [n-1:0] acc_vec;                 // Access strobes, flat

   always_comb begin
      req_out  = '0;
      wait_out = '0;
      found    = 1'b0;
      for (int i = 0; i < n; i++) begin
         acc_vec[i] = req_in[i].access;
         if (req_in[i].access) begin
            if (!found) begin
               req_out     = req_in[i];   // Lowest index wins
               wait_out[i] = wait_in;     // Winner sees sink wait
               found       = 1'b1;
            end else begin
               wait_out[i] = 1'b1;        // Losers hold
            end
         end
      end
   end

   // Exactly one requester moves per cycle when the sink is open
   always_comb begin
      assert final ((req_out.access !== 1'b1) || wait_in ||
                    ($countones(acc_vec & ~wait_out) == 1))
         else $error("emesh_priority_mux: %0d inputs unwaited",
                     $countones(acc_vec & ~wait_out));
   end

endmodule

`default_nettype wire

//--- design/mio_route_pkg.sv
`default_nettype none

package mio_route_pkg;

   //##########################################################
   // Widths and address map
   //##########################################################

   localparam int aw = 32;                // Address and data width

   localparam logic [11:0] id       = 12'h810; // Local block id in dstaddr[31:20]
   localparam logic [11:0] remap_id = 12'h3E0; // Outgoing slave id over MIO
   localparam logic [3:0] egroup_rr = 4'hD;    // Read-response group in dstaddr[19:16]

   localparam int reg_words = 16;         // Register file depth
   localparam int reg_idx_w = 4;          // Index from dstaddr[5:2]

   //##########################################################
   // Packet types
   //##########################################################

   // Field order matches the flat emesh packet with write on top
   typedef struct packed {
      logic          write;               // 1 = write, 0 = read
      logic [1:0]    datamode;            // Transfer size
      logic [4:0]    ctrlmode;            // Sideband control
      logic [aw-1:0] dstaddr;             // Destination address
      logic [aw-1:0] data;                // Write data / read payload
      logic [aw-1:0] srcaddr;             // Return address for reads
   } emesh_packet_t;                      // 104 bits

   // Strobe plus packet, used on every link
   typedef struct packed {
      logic          access;              // Packet valid this cycle
      emesh_packet_t packet;
   } emesh_req_t;                         // 105 bits

   // Where a MIO receive packet goes
   typedef enum logic [1:0] {
      route_rr,                           // Slave read response
      route_mwr,                          // Master write
      route_mrd                           // Master read
   } rx_route_e;

endpackage

`default_nettype wire
